// File: logic/alu_exec.sv
// ALU stage of the core; computes one operation per load and holds the result for writeback
`default_nettype none

module alu_exec #(
  parameter int XLEN = core_pkg::XLEN
) (
  input  logic                clk,
  input  logic                rst_n,
  input  core_pkg::exec_req_t req,
  input  logic                load,
  output logic [XLEN-1:0]     result
);
  import core_pkg::*;

  logic [XLEN-1:0] a_op;
  logic [XLEN-1:0] b_op;
  logic [XLEN-1:0] next_result;

  assign a_op = req.a;
  assign b_op = req.b;

  // Shift amounts of XLEN or more give zero
  always_comb begin
    unique case (req.op)
      OP_ADD:  next_result = a_op + b_op;
      OP_SUB:  next_result = a_op - b_op;
      OP_AND:  next_result = a_op & b_op;
      OP_OR:   next_result = a_op | b_op;
      OP_XOR:  next_result = a_op ^ b_op;
      OP_NOT:  next_result = ~a_op;
      OP_SLL:  next_result = a_op << b_op;
      OP_SRL:  next_result = a_op >> b_op;
      OP_LDI:  next_result = XLEN'(req.imm);
      default: next_result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
    end else if (load) begin
      result <= next_result;
    end
  end

  a_add: assert property (@(posedge clk) disable iff (!rst_n)
    load && req.op == OP_ADD |=> result == $past(a_op) + $past(b_op));
  a_sub: assert property (@(posedge clk) disable iff (!rst_n)
    load && req.op == OP_SUB |=> result == $past(a_op) - $past(b_op));
  a_and: assert property (@(posedge clk) disable iff (!rst_n)
    load && req.op == OP_AND |=> result == ($past(a_op) & $past(b_op)));
  a_or: assert property (@(posedge clk) disable iff (!rst_n)
    load && req.op == OP_OR |=> result == ($past(a_op) | $past(b_op)));
  a_xor: assert property (@(posedge clk) disable iff (!rst_n)
    load && req.op == OP_XOR |=> result == ($past(a_op) ^ $past(b_op)));
  a_not: assert property (@(posedge clk) disable iff (!rst_n)
    load && req.op == OP_NOT |=> result == ~$past(a_op));
  a_sll: assert property (@(posedge clk) disable iff (!rst_n)
    load && req.op == OP_SLL |=> result == ($past(a_op) << $past(b_op)));
  a_srl: assert property (@(posedge clk) disable iff (!rst_n)
    load && req.op == OP_SRL |=> result == ($past(a_op) >> $past(b_op)));
  a_ldi: assert property (@(posedge clk) disable iff (!rst_n)
    load && req.op == OP_LDI |=> result == XLEN'($past(req.imm)));
  a_undef: assert property (@(posedge clk) disable iff (!rst_n)
    load && !(req.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SLL,
                             OP_SRL, OP_LDI}) |=> result == '0);

endmodule

`default_nettype wire

// File: logic/core_pkg.sv
// Shared widths, instruction and report formats and encodings for the multicycle core
`default_nettype none

package core_pkg;

  localparam int XLEN      = 32;
  localparam int NUM_REGS  = 16;
  localparam int REG_IDX_W = 4;
  localparam int IMM_W     = 16;
  localparam int SEQ_W     = 32;

  typedef enum logic [7:0] {
    OP_ADD = 8'h00,
    OP_SUB = 8'h01,
    OP_AND = 8'h02,
    OP_OR  = 8'h03,
    OP_XOR = 8'h04,
    OP_NOT = 8'h05,
    OP_SLL = 8'h06,
    OP_SRL = 8'h07,
    OP_LDI = 8'h08
  } opcode_t;

  // Immediate is bits 31:16, so rs2 doubles as its low nibble
  typedef struct packed {
    logic [IMM_W-REG_IDX_W-1:0] imm_hi;
    logic [REG_IDX_W-1:0]       rs2;
    logic [REG_IDX_W-1:0]       rs1;
    logic [REG_IDX_W-1:0]       rd;
    opcode_t                    op;
  } instr_t;

  typedef enum logic [1:0] {
    ST_FETCH = 2'd0,
    ST_EXEC  = 2'd1,
    ST_WB    = 2'd2
  } stage_t;

  typedef struct packed {
    logic [SEQ_W-1:0]     seq;
    logic [REG_IDX_W-1:0] rd;
    logic [XLEN-1:0]      value;
  } wb_t;

  typedef struct packed {
    opcode_t              op;
    logic [REG_IDX_W-1:0] rd;
    logic [XLEN-1:0]      a;
    logic [XLEN-1:0]      b;
    logic [IMM_W-1:0]     imm;
  } exec_req_t;

  // Full 16-bit immediate of an instruction word
  function automatic logic [IMM_W-1:0] instr_imm(instr_t i);
    return {i.imm_hi, i.rs2};
  endfunction

endpackage

`default_nettype wire

// File: logic/mini_core.sv
// Top level of the multicycle core with an instruction stream in and a writeback report stream out
`default_nettype none

module mini_core #(
  parameter int XLEN     = core_pkg::XLEN,
  parameter int NUM_REGS = core_pkg::NUM_REGS
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  core_pkg::instr_t in_instr,
  output logic             in_ready,
  output logic             out_valid,
  output core_pkg::wb_t    out_wb,
  input  logic             out_ready
);
  import core_pkg::*;

  logic                 instr_valid;
  instr_t               instr;
  logic                 instr_ready;
  logic [REG_IDX_W-1:0] rs1_idx;
  logic [REG_IDX_W-1:0] rs2_idx;
  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;
  exec_req_t            req;
  logic [XLEN-1:0]      alu_result;
  logic                 alu_load;
  logic                 wb_valid;
  wb_t                  wb;
  logic                 wb_ready;
  logic                 rf_we;

  // Execute is the stage that neither fetches nor reports
  assign alu_load = !instr_ready && !wb_valid;

  stream_slot #(.payload_t(instr_t)) u_in_slot (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (in_valid),
    .s_data  (in_instr),
    .s_ready (in_ready),
    .m_valid (instr_valid),
    .m_data  (instr),
    .m_ready (instr_ready)
  );

  seq_ctrl #(.XLEN(XLEN), .NUM_REGS(NUM_REGS)) u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .rs1_idx     (rs1_idx),
    .rs2_idx     (rs2_idx),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .req         (req),
    .alu_result  (alu_result),
    .wb_valid    (wb_valid),
    .wb          (wb),
    .wb_ready    (wb_ready),
    .rf_we       (rf_we)
  );

  reg_file #(.XLEN(XLEN), .NUM_REGS(NUM_REGS)) u_rf (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .wr_idx   (wb.rd),
    .wr_data  (wb.value)
  );

  alu_exec #(.XLEN(XLEN)) u_alu (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .load   (alu_load),
    .result (alu_result)
  );

  stream_slot #(.payload_t(wb_t)) u_out_slot (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (wb_valid),
    .s_data  (wb),
    .s_ready (wb_ready),
    .m_valid (out_valid),
    .m_data  (out_wb),
    .m_ready (out_ready)
  );

endmodule

`default_nettype wire

// File: logic/reg_file.sv
// Register file of the core with two combinational read ports and one write port
`default_nettype none

module reg_file #(
  parameter int XLEN     = core_pkg::XLEN,
  parameter int NUM_REGS = core_pkg::NUM_REGS
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [core_pkg::REG_IDX_W-1:0] rs1_idx,
  input  logic [core_pkg::REG_IDX_W-1:0] rs2_idx,
  output logic [XLEN-1:0]                rs1_data,
  output logic [XLEN-1:0]                rs2_data,
  input  logic                           we,
  input  logic [core_pkg::REG_IDX_W-1:0] wr_idx,
  input  logic [XLEN-1:0]                wr_data
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wr_idx] <= wr_data;
    end
  end

  a_write_lands: assert property (@(posedge clk) disable iff (!rst_n)
    we |=> regs[$past(wr_idx)] == $past(wr_data));

  // Every other entry keeps its value
  for (genvar g = 0; g < NUM_REGS; g++) begin : g_hold
    a_reg_hold: assert property (@(posedge clk) disable iff (!rst_n)
      !(we && wr_idx == REG_IDX_W'(g)) |=> $stable(regs[g]));
  end

endmodule

`default_nettype wire

// File: logic/seq_ctrl.sv
// Fetch, execute and writeback sequencer of the core; stalls in writeback under back-pressure
`default_nettype none

module seq_ctrl #(
  parameter int XLEN     = core_pkg::XLEN,
  parameter int NUM_REGS = core_pkg::NUM_REGS
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           instr_valid,
  input  core_pkg::instr_t               instr,
  output logic                           instr_ready,
  output logic [core_pkg::REG_IDX_W-1:0] rs1_idx,
  output logic [core_pkg::REG_IDX_W-1:0] rs2_idx,
  input  logic [XLEN-1:0]                rs1_data,
  input  logic [XLEN-1:0]                rs2_data,
  output core_pkg::exec_req_t            req,
  input  logic [XLEN-1:0]                alu_result,
  output logic                           wb_valid,
  output core_pkg::wb_t                  wb,
  input  logic                           wb_ready,
  output logic                           rf_we
);
  import core_pkg::*;

  stage_t               stage;
  logic [SEQ_W-1:0]     pc;
  instr_t               ir;
  logic [REG_IDX_W-1:0] rd_q;
  logic                 fetch_xfer;

  assign instr_ready = (stage == ST_FETCH);
  assign fetch_xfer  = instr_valid && instr_ready;
  assign wb_valid    = (stage == ST_WB);
  assign rf_we       = wb_valid && wb_ready;

  // Register file is read combinationally during execute
  assign rs1_idx = ir.rs1;
  assign rs2_idx = ir.rs2;

  always_comb begin
    req.op  = ir.op;
    req.rd  = ir.rd;
    req.a   = rs1_data;
    req.b   = rs2_data;
    req.imm = instr_imm(ir);
  end

  // Report carries the count of the instruction it belongs to
  always_comb begin
    wb.seq   = pc;
    wb.rd    = rd_q;
    wb.value = alu_result;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage <= ST_FETCH;
      pc    <= '0;
    end else begin
      unique case (stage)
        ST_FETCH: begin
          if (fetch_xfer) begin
            stage <= ST_EXEC;
            pc    <= pc + 1'b1;
          end
        end
        ST_EXEC: stage <= ST_WB;
        ST_WB: begin
          if (wb_ready) begin
            stage <= ST_FETCH;
          end
        end
        default: stage <= ST_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_xfer) begin
      ir <= instr;
    end
    // Decode capture of the destination
    if (stage == ST_EXEC) begin
      rd_q <= ir.rd;
    end
  end

  a_stage_legal: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(stage) && stage inside {ST_FETCH, ST_EXEC, ST_WB});

  a_fetch_to_exec: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_xfer |=> stage == ST_EXEC);

  a_exec_to_wb: assert property (@(posedge clk) disable iff (!rst_n)
    stage == ST_EXEC |=> stage == ST_WB);

  a_wb_to_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    stage == ST_WB && wb_ready |=> stage == ST_FETCH);

  // Back-pressure freezes the report and the stage
  a_wb_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stage == ST_WB && !wb_ready |=> stage == ST_WB && $stable(wb));

  a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_xfer |=> pc == $past(pc) + 1'b1);

  a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !fetch_xfer |=> $stable(pc));

  a_ir_hold: assert property (@(posedge clk) disable iff (!rst_n)
    stage != ST_FETCH |=> $stable(ir));

  // One register write per report, never two in a row
  a_we_once: assert property (@(posedge clk) disable iff (!rst_n)
    rf_we |=> stage == ST_FETCH && !rf_we);

  a_rd_range: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> int'(rd_q) < NUM_REGS);

endmodule

`default_nettype wire

// File: logic/stream_slot.sv
// One-entry valid/ready buffer for any payload type, placed on the core's input and output
`default_nettype none

module stream_slot #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     s_valid,
  input  payload_t s_data,
  output logic     s_ready,
  output logic     m_valid,
  output payload_t m_data,
  input  logic     m_ready
);

  logic     full;
  logic     live;
  payload_t data_q;

  // Take a new item when empty or when the held one leaves now
  assign s_ready = live && (!full || m_ready);
  assign m_valid = full;
  assign m_data  = data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
      live <= 1'b0;
    end else begin
      live <= 1'b1;
      if (s_ready) begin
        full <= s_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s_valid && s_ready) begin
      data_q <= s_data;
    end
  end

  // Stalled item stays offered and unchanged
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_mini_core \
  -f verilog.f -o sim_mini_core > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_mini_core > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
exit 0

// File: test/core_stimulus.txt
# name, instruction word, expected rd, expected value (all hex but the name)
ldi_r1 12340108 1 00001234
ldi_r2 F00F0208 2 0000F00F
ldi_r3 00040308 3 00000004
ldi_r4 00200408 4 00000020
ldi_r5 FFFF0508 5 0000FFFF
add_r6 00021600 6 00010243
sub_r7 00021701 7 FFFF2225
and_r8 00021802 8 00001004
or_r9 00021903 9 0000F23F
xor_r10 00021A04 A 0000E23B
not_r11 00001B05 B FFFFEDCB
sll_by_4 00031C06 C 00012340
srl_by_4 00032D07 D 00000F00
sll_by_32 00041E06 E 00000000
srl_by_32 00045F07 F 00000000
undef_op 0002213C 1 00000000
or_after_undef 00051303 3 0000FFFF
chain_add 00066600 6 00020486
chain_sub 00026601 6 00011477
chain_xor 00036604 6 0001EB88
chain_not 00006705 7 FFFE1477
chain_add_r0 00067000 0 FFFFFFFF
ldi_r9 00030908 9 00000003
chain_srl 00090A07 A 1FFFFFFF
chain_sll 0009AB06 B FFFFFFF8

// File: test/tb_clock.sv
// Clock and reset source for the core testbench, 10 ns period with reset held for two cycles
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: test/tb_mini_core.sv
// Testbench for the core; runs the stimulus file under random gaps and back-pressure
`default_nettype none

module tb_mini_core;
  timeunit 1ns;
  timeprecision 100ps;
  import core_pkg::*;

  localparam int    MAX_TESTS = 64;
  localparam int    NAME_W    = 8 * 16;
  localparam string STIM_FILE = "test/core_stimulus.txt";

  logic   clk;
  logic   rst_n;
  logic   in_valid  = 1'b0;
  instr_t in_instr  = '0;
  logic   out_ready = 1'b0;
  logic   in_ready;
  logic   out_valid;
  wb_t    out_wb;

  logic [NAME_W-1:0]    names   [MAX_TESTS];
  instr_t               instrs  [MAX_TESTS];
  logic [REG_IDX_W-1:0] exp_rd  [MAX_TESTS];
  logic [XLEN-1:0]      exp_val [MAX_TESTS];

  int          n_lines         = 0;
  logic        run_en          = 1'b0;
  logic [15:0] lfsr            = 16'd37021;
  int          sent            = 0;
  logic        accepted_any    = 1'b0;
  int          rcv_count       = 0;
  int          value_errors    = 0;
  int          protocol_errors = 0;
  int          run_errors      = 0;

  tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mini_core #(.XLEN(XLEN), .NUM_REGS(NUM_REGS)) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_instr  (in_instr),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_wb    (out_wb),
    .out_ready (out_ready)
  );

  // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_step(lfsr);
  endtask

  function automatic wb_t expected_wb(int k);
    wb_t w;
    w.seq   = SEQ_W'(k + 1);
    w.rd    = exp_rd[k];
    w.value = exp_val[k];
    return w;
  endfunction

  task automatic check_wb(input logic [NAME_W-1:0] name, input wb_t exp, input wb_t act);
    if (act !== exp) begin
      value_errors++;
      $display("Error %0s: expected seq %0d rd %0d value %h, got seq %0d rd %0d value %h",
               name, exp.seq, exp.rd, exp.value, act.seq, act.rd, act.value);
    end
  endtask

  task automatic load_stimulus();
    int                fd;
    int                code;
    logic [8*128-1:0]  line;
    logic [NAME_W-1:0] name;
    logic [31:0]       word;
    logic [31:0]       rd_word;
    logic [XLEN-1:0]   value;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      run_errors++;
      $display("Cannot open the stimulus file %0s", STIM_FILE);
    end else begin
      while (!$feof(fd) && n_lines < MAX_TESTS) begin
        line = '0;
        code = $fgets(line, fd);
        // Comment and blank lines do not yield four fields
        if (code > 0) begin
          if ($sscanf(line, "%s %h %h %h", name, word, rd_word, value) == 4) begin
            names[n_lines]   = name;
            instrs[n_lines]  = instr_t'(word);
            exp_rd[n_lines]  = rd_word[REG_IDX_W-1:0];
            exp_val[n_lines] = value;
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Input side and out_ready, both fed from the one LFSR
  always @(posedge clk) begin : drive
    logic [2:0] r;
    logic       bit_v;
    logic       go;
    if (run_en) begin
      for (int i = 0; i < 3; i++) begin
        draw_bit(bit_v);
        r[i] = bit_v;
      end
      // Low for three draws out of eight
      out_ready <= (r > 3'd2);
      if (in_valid && in_ready) begin
        sent = sent + 1;
        accepted_any <= 1'b1;
      end
      if (!in_valid || in_ready) begin
        go = 1'b0;
        if (sent < n_lines) begin
          draw_bit(go);
        end
        in_valid <= go;
        if (go) begin
          in_instr <= instrs[sent];
        end
      end
    end
  end

  always @(posedge clk) begin : monitor
    if (run_en) begin
      if (out_valid && !accepted_any) begin
        protocol_errors++;
        $display("A report was offered before any instruction had been accepted");
      end
      if (out_valid && out_ready) begin
        if (rcv_count >= n_lines) begin
          protocol_errors++;
          $display("An extra report arrived after all instructions were reported");
        end else begin
          check_wb(names[rcv_count], expected_wb(rcv_count), out_wb);
        end
        rcv_count <= rcv_count + 1;
      end
    end
  end

  initial begin : main
    int cycles;
    int limit;
    cycles = 0;
    load_stimulus();
    if (n_lines == 0 && run_errors == 0) begin
      run_errors++;
      $display("The stimulus file holds no tests");
    end
    if (run_errors == 0) begin
      limit = n_lines * 20 + 100;
      @(posedge rst_n);
      run_en = 1'b1;
      while (rcv_count < n_lines && cycles < limit) begin
        @(posedge clk);
        cycles++;
      end
      if (rcv_count < n_lines) begin
        run_errors++;
        $display("Timeout: reports stopped arriving, %0d of %0d received after %0d cycles",
                 rcv_count, n_lines, cycles);
      end else begin
        // Quiet tail to catch duplicated reports
        repeat (10) @(posedge clk);
      end
    end
    $display("Tests %0d, reports %0d, value errors %0d, protocol errors %0d, run errors %0d",
             n_lines, rcv_count, value_errors, protocol_errors, run_errors);
    if (value_errors + protocol_errors + run_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
logic/core_pkg.sv
logic/stream_slot.sv
logic/seq_ctrl.sv
logic/reg_file.sv
logic/alu_exec.sv
logic/mini_core.sv
test/tb_clock.sv
test/tb_mini_core.sv
